/* src.f */
verilog/bus_pkg.sv
verilog/priority_arbiter.sv
verilog/addr_window.sv
verilog/addr_translator.sv
verilog/bus_sequencer.sv
verilog/bus_controller.sv
test/bus_checker.sv
test/tb_bus_controller.sv

/* test/bus_checker.sv */
`timescale 1ns/10ps

module bus_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                done,
    input  int                  test_num,
    input  bus_pkg::dev_vec_t   mask,
    input  bus_pkg::dev_idx_t   idx,
    input  bus_pkg::bus_word_t  addr,
    input  logic                we,
    input  logic [2:0]          burst,
    input  bus_pkg::bus_word_t  mdata,
    input  bus_pkg::bus_word_t  sdata,
    input  bus_pkg::dev_vec_t   req,
    input  bus_pkg::ctrl_bank_t ctrl_in,
    input  bus_pkg::dev_vec_t   ack,
    input  bus_pkg::ctrl_t      ctrl_out,
    input  bus_pkg::bus_word_t  bus_out,
    output int                  err_count
);

    int pass_count;
    int fail_count;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs(input bus_pkg::dev_vec_t exp_ack,
                                 input bus_pkg::ctrl_t exp_ctrl,
                                 input bus_pkg::bus_word_t exp_bus);
        compare("ack", exp_ack, ack);
        compare("ctrl_out", exp_ctrl, ctrl_out);
        compare("bus_out", exp_bus, bus_out);
    endtask

    initial begin
        bus_pkg::dev_vec_t  master;
        bus_pkg::dev_vec_t  slave;
        bus_pkg::dev_idx_t  midx;
        bus_pkg::dev_idx_t  sidx;
        bus_pkg::ctrl_t     forced;
        bus_pkg::bus_word_t phys;
        bus_pkg::bus_word_t data;
        int                 cur_test;
        int                 start_errs;
        int                 waiting;
        int                 tail;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        waiting    = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                waiting = 0;
            end else if (ack == '0) begin
                // A pending request must see its ack on the next cycle
                if (req != '0) begin
                    waiting++;
                end
                if (waiting == 2) begin
                    err_count++;
                    fail_count++;
                    $display("Test %0d: request was not acknowledged on the next cycle", test_num);
                end
            end else begin
                waiting    = 0;
                cur_test   = test_num;
                start_errs = err_count;
                midx       = idx;
                sidx       = addr[31:29];
                master     = mask & (~mask + 8'd1);
                slave      = 8'd1 << sidx;
                phys       = {3'b000, addr[28:0]};
                forced     = {3'b000, burst, we, 1'b1};
                data       = we ? mdata : sdata;
                // Grant cycle shows the raw master word
                check_outputs(master, ctrl_in[midx], addr);
                @(negedge clk);
                check_outputs(master, ctrl_in[midx], phys);
                @(negedge clk);
                // Slave ack, address held, wait forced
                check_outputs(slave, forced, phys);
                do begin
                    @(negedge clk);
                    check_outputs(slave, ctrl_in[sidx], data);
                end while (req[midx] === 1'b1);
                tail = 0;
                @(negedge clk);
                while (ack != '0 && tail < 2) begin
                    check_outputs(slave, ctrl_in[sidx], data);
                    tail++;
                    @(negedge clk);
                end
                if (ack != '0) begin
                    err_count++;
                    $display("Test %0d: ack stayed high after the request was dropped", cur_test);
                end
                // Next request may already be pending in this idle cycle
                if (ack == '0 && req != '0) begin
                    waiting = 1;
                end
                if (err_count == start_errs) begin
                    pass_count++;
                    $display("Test %0d passed", cur_test);
                end else begin
                    fail_count++;
                    $display("Test %0d failed", cur_test);
                end
            end
        end
    end

    always @(posedge done) begin
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
    end

endmodule

/* test/bus_patterns.txt */
// mask idx addr we burst master_data slave_data busy_cycles
// idx is the lowest set bit of mask, addr[31:29] selects the slave
01 0 20001000 1 2 a5a50001 5a5a0001 3
02 1 40000040 0 3 a5a50002 5a5a0002 2
06 1 e0ff0000 1 0 11112222 33334444 4
80 7 12345678 0 7 0badf00d c0ffee00 1
f0 4 bfffffff 1 5 deadbeef feedface 5
ff 0 7ffffffc 0 1 01020304 05060708 2
18 3 c0000000 1 4 89abcdef 76543210 6
a0 5 00000004 0 6 13579bdf 2468ace0 3
40 6 3abcdef0 1 2 55aa55aa aa55aa55 1
0c 2 fedcba98 0 0 0f0f0f0f f0f0f0f0 4
81 0 5555aaaa 1 3 12121212 34343434 2
20 5 8000ffff 0 7 cafebabe beefcafe 5
10 4 dead0000 1 1 00000001 80000000 3
e0 5 60000001 0 2 fffffffe 00000000 2
08 3 a0000010 1 6 abcdabcd dcbadcba 1
03 0 fffffff0 0 5 7e7e7e7e e7e7e7e7 4

/* test/tb_bus_controller.sv */
`timescale 1ns/10ps

module tb_bus_controller;

    logic                clk;
    logic                rst;
    bus_pkg::dev_vec_t   req;
    bus_pkg::ctrl_bank_t ctrl_in;
    bus_pkg::bus_bank_t  bus_in;
    bus_pkg::dev_vec_t   ack;
    bus_pkg::ctrl_t      ctrl_out;
    bus_pkg::bus_word_t  bus_out;

    // Fields of the pattern being run, watched by the checker as well
    int                 test_num;
    bus_pkg::dev_vec_t  mask;
    bus_pkg::dev_idx_t  idx;
    bus_pkg::bus_word_t addr;
    logic               we;
    logic [2:0]         burst;
    bus_pkg::bus_word_t mdata;
    bus_pkg::bus_word_t sdata;
    int                 busy;
    logic               done;
    int                 err_count;

    // Room for 32 patterns of 8 words each
    logic [31:0] pat_mem [256];
    int          num_patterns;
    int          seed;
    int          cycle_count;
    int          cycle_limit;

    bus_controller u_dut (.*);

    bus_checker u_checker (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped at cycle %0d, a transfer did not complete", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic take_pattern(input int n);
        test_num = n + 1;
        mask     = pat_mem[n*8][7:0];
        idx      = pat_mem[n*8+1][2:0];
        addr     = pat_mem[n*8+2];
        we       = pat_mem[n*8+3][0];
        burst    = pat_mem[n*8+4][2:0];
        mdata    = pat_mem[n*8+5];
        sdata    = pat_mem[n*8+6];
        busy     = pat_mem[n*8+7];
    endtask

    // Request, address phase, data phase and release of one transfer
    task automatic run_transfer();
        logic [31:0] rnd;
        // Devices outside the transfer drive noise on their slices
        for (int i = 0; i < bus_pkg::num_devices; i++) begin
            rnd        = $random(seed);
            bus_in[i]  = rnd;
            rnd        = $random(seed);
            ctrl_in[i] = rnd[7:0];
        end
        ctrl_in[idx] = {3'b000, burst, we, 1'b0};
        bus_in[idx]  = addr;
        req          = mask;
        do begin
            wait_cycle();
        end while (ack[idx] !== 1'b1);
        // Master ack drops once the slave is acknowledged
        do begin
            wait_cycle();
        end while (ack[idx] === 1'b1);
        bus_in[idx]         = mdata;
        bus_in[addr[31:29]] = sdata;
        repeat (busy) wait_cycle();
        req = '0;
        do begin
            wait_cycle();
        end while (ack !== '0);
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        req     = '0;
        ctrl_in = '0;
        bus_in  = '0;
        {mask, idx, addr, we, burst, mdata, sdata} = '0;
        test_num    = 0;
        busy        = 0;
        done        = 1'b0;
        seed        = 32'heaba_c640;
        cycle_count = 0;
        for (int i = 0; i < 256; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("test/bus_patterns.txt", pat_mem);
        // A zero request mask marks the end of the table
        num_patterns = 0;
        cycle_limit  = 50;
        while (num_patterns < 32 && pat_mem[num_patterns*8] != '0) begin
            cycle_limit += pat_mem[num_patterns*8+7] + 10;
            num_patterns++;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet bus for a few cycles before the first request
        repeat (3) wait_cycle();
        for (int n = 0; n < num_patterns; n++) begin
            take_pattern(n);
            run_transfer();
        end
        repeat (2) wait_cycle();
        done = 1'b1;
        #1;
        if (err_count == 0 && num_patterns > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog/addr_translator.sv */
`timescale 1ns/10ps

module addr_translator (
    input  bus_pkg::bus_word_t addr_word,
    output bus_pkg::dev_vec_t  dev_mask,
    output bus_pkg::bus_word_t phys_addr
);

    bus_pkg::dev_vec_t hits;
    bus_pkg::bus_bank_t win_addr;

    // One window decoder per device, all fed the same virtual address
    for (genvar k = 0; k < bus_pkg::num_devices; k++) begin : g_window
        addr_window u_window (
            .index     (bus_pkg::dev_idx_t'(k)),
            .addr      (addr_word),
            .hit       (hits[k]),
            .phys_addr (win_addr[k])
        );
    end

    // At most one window hits, so the hit vector is already one-hot
    assign dev_mask = hits;

    // OR of the hitting windows, zero when nothing decodes
    always_comb begin
        phys_addr = '0;
        for (int i = 0; i < bus_pkg::num_devices; i++) begin
            if (hits[i]) begin
                phys_addr = phys_addr | win_addr[i];
            end
        end
    end

endmodule

/* verilog/addr_window.sv */
`timescale 1ns/10ps

module addr_window (
    input  bus_pkg::dev_idx_t  index,
    input  bus_pkg::bus_word_t addr,
    output logic               hit,
    output bus_pkg::bus_word_t phys_addr
);

    bus_pkg::dev_idx_t select;

    // Device select field sits in the top address bits
    assign select = addr[bus_pkg::bus_width-1:bus_pkg::window_bits];

    assign hit = (select == index);

    // Device-local address is the virtual address without its select field
    always_comb begin
        phys_addr = addr;
        phys_addr[bus_pkg::bus_width-1:bus_pkg::window_bits] = '0;
    end

endmodule

/* verilog/bus_controller.sv */
`timescale 1ns/10ps

module bus_controller (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::dev_vec_t   req,
    input  bus_pkg::ctrl_bank_t ctrl_in,
    input  bus_pkg::bus_bank_t  bus_in,
    output bus_pkg::dev_vec_t   ack,
    output bus_pkg::ctrl_t      ctrl_out,
    output bus_pkg::bus_word_t  bus_out
);

    bus_pkg::dev_vec_t  grant;
    bus_pkg::dev_vec_t  dev_mask;
    bus_pkg::bus_word_t addr_word;
    bus_pkg::bus_word_t phys_addr;
    logic               load;
    logic               clear;

    priority_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .load  (load),
        .clear (clear),
        .grant (grant)
    );

    addr_translator u_translator (
        .addr_word (addr_word),
        .dev_mask  (dev_mask),
        .phys_addr (phys_addr)
    );

    bus_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .grant     (grant),
        .ctrl_in   (ctrl_in),
        .bus_in    (bus_in),
        .dev_mask  (dev_mask),
        .phys_addr (phys_addr),
        .load      (load),
        .clear     (clear),
        .addr_word (addr_word),
        .ack       (ack),
        .ctrl_out  (ctrl_out),
        .bus_out   (bus_out)
    );

endmodule

/* verilog/bus_pkg.sv */
package bus_pkg;

    // Bus geometry
    localparam int num_devices = 8;
    localparam int bus_width   = 32;

    // Low address bits kept as the device-local address
    localparam int window_bits = 29;
    // Top address bits that pick the target device
    localparam int sel_bits    = bus_width - window_bits;

    // One bit per device: req, ack, grant, window hits
    typedef logic [num_devices-1:0] dev_vec_t;

    // Device number, same width as the select field of an address
    typedef logic [sel_bits-1:0] dev_idx_t;

    // Address or data word on the shared bus
    typedef logic [bus_width-1:0] bus_word_t;

    // Control word, wait in bit 0 up to reserved in bits 7:5
    typedef struct packed {
        logic [2:0] reserved;
        logic [2:0] burst;
        logic       we;
        logic       wait_flag;
    } ctrl_t;

    // Per-device input banks, slice i is driven by device i
    typedef ctrl_t     [num_devices-1:0] ctrl_bank_t;
    typedef bus_word_t [num_devices-1:0] bus_bank_t;

    // Transfer sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_ack,
        st_addr,
        st_ack_slave,
        st_busy,
        st_finish
    } seq_state_t;

endpackage

/* verilog/bus_sequencer.sv */
`timescale 1ns/10ps

module bus_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::dev_vec_t   req,
    input  bus_pkg::dev_vec_t   grant,
    input  bus_pkg::ctrl_bank_t ctrl_in,
    input  bus_pkg::bus_bank_t  bus_in,
    input  bus_pkg::dev_vec_t   dev_mask,
    input  bus_pkg::bus_word_t  phys_addr,
    output logic                load,
    output logic                clear,
    output bus_pkg::bus_word_t  addr_word,
    output bus_pkg::dev_vec_t   ack,
    output bus_pkg::ctrl_t      ctrl_out,
    output bus_pkg::bus_word_t  bus_out
);

    bus_pkg::seq_state_t state;
    bus_pkg::seq_state_t state_next;

    // Latched transfer registers
    bus_pkg::dev_vec_t  initiator_q;
    bus_pkg::dev_vec_t  slave_q;
    logic               we_q;
    logic [2:0]         burst_q;
    bus_pkg::bus_word_t prev_bus_q;

    bus_pkg::ctrl_t     master_ctrl;
    bus_pkg::ctrl_t     slave_ctrl;
    bus_pkg::bus_word_t master_bus;
    bus_pkg::bus_word_t slave_bus;
    logic               req_dropped;

    // One-hot select from a control bank
    function automatic bus_pkg::ctrl_t pick_ctrl(input bus_pkg::ctrl_bank_t bank,
                                                 input bus_pkg::dev_vec_t   sel);
        bus_pkg::ctrl_t result;
        result = '0;
        for (int i = 0; i < bus_pkg::num_devices; i++) begin
            if (sel[i]) begin
                result = result | bank[i];
            end
        end
        return result;
    endfunction

    // One-hot select from a bus word bank
    function automatic bus_pkg::bus_word_t pick_bus(input bus_pkg::bus_bank_t bank,
                                                    input bus_pkg::dev_vec_t  sel);
        bus_pkg::bus_word_t result;
        result = '0;
        for (int i = 0; i < bus_pkg::num_devices; i++) begin
            if (sel[i]) begin
                result = result | bank[i];
            end
        end
        return result;
    endfunction

    assign master_ctrl = pick_ctrl(ctrl_in, grant);
    assign master_bus  = pick_bus(bus_in, grant);
    assign slave_ctrl  = pick_ctrl(ctrl_in, slave_q);
    assign slave_bus   = pick_bus(bus_in, slave_q);

    // Master's word goes to the translator during the address cycle
    assign addr_word = master_bus;

    // Transfer ends once the initiating master lowers its request
    assign req_dropped = ((initiator_q & req) == '0);

    assign load  = (state == bus_pkg::st_idle);
    assign clear = (state == bus_pkg::st_finish);

    always_comb begin
        case (state)
            bus_pkg::st_idle:      state_next = (req != '0) ? bus_pkg::st_ack : bus_pkg::st_idle;
            bus_pkg::st_ack:       state_next = bus_pkg::st_addr;
            bus_pkg::st_addr:      state_next = bus_pkg::st_ack_slave;
            bus_pkg::st_ack_slave: state_next = bus_pkg::st_busy;
            bus_pkg::st_busy:      state_next = req_dropped ? bus_pkg::st_finish : bus_pkg::st_busy;
            default:               state_next = bus_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= bus_pkg::st_idle;
            initiator_q <= '0;
            slave_q     <= '0;
        end else begin
            state <= state_next;
            if (state == bus_pkg::st_ack) begin
                initiator_q <= grant;
            end
            // Slave comes from the window hit of the address cycle
            if (state == bus_pkg::st_addr) begin
                slave_q <= dev_mask;
            end else if (state == bus_pkg::st_finish) begin
                slave_q <= '0;
            end
        end
    end

    // Master's direction and burst, taken in the grant cycle
    always_ff @(posedge clk) begin
        prev_bus_q <= bus_out;
        if (state == bus_pkg::st_ack) begin
            we_q    <= master_ctrl.we;
            burst_q <= master_ctrl.burst;
        end
    end

    // Ack, control and bus routing per state
    always_comb begin
        case (state)
            bus_pkg::st_addr: begin
                ack      = grant;
                ctrl_out = master_ctrl;
                bus_out  = phys_addr;
            end
            bus_pkg::st_ack_slave: begin
                // Address held one more cycle for the slave, wait forced
                ack                = slave_q;
                ctrl_out           = '0;
                ctrl_out.burst     = burst_q;
                ctrl_out.we        = we_q;
                ctrl_out.wait_flag = 1'b1;
                bus_out            = prev_bus_q;
            end
            bus_pkg::st_busy, bus_pkg::st_finish: begin
                ack      = slave_q;
                ctrl_out = slave_ctrl;
                bus_out  = we_q ? master_bus : slave_bus;
            end
            default: begin
                ack      = grant;
                ctrl_out = master_ctrl;
                bus_out  = master_bus;
            end
        endcase
    end

endmodule

/* verilog/priority_arbiter.sv */
`timescale 1ns/10ps

module priority_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::dev_vec_t req,
    input  logic              load,
    input  logic              clear,
    output bus_pkg::dev_vec_t grant
);

    bus_pkg::dev_vec_t lowest;
    bus_pkg::dev_vec_t grant_q;

    // Scan from the top down so the lowest set bit is the last one kept
    always_comb begin
        lowest = '0;
        for (int i = bus_pkg::num_devices - 1; i >= 0; i--) begin
            if (req[i]) begin
                lowest    = '0;
                lowest[i] = 1'b1;
            end
        end
    end

    // Grant register
    // clear wins over load, both never come in the same state anyway
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= '0;
        end else if (clear) begin
            grant_q <= '0;
        end else if (load) begin
            grant_q <= lowest;
        end
    end

    assign grant = grant_q;

endmodule
